/* filelist.f */
+incdir+hw
hw/axi_rd_pkg.sv
hw/axi_rd_burst_seq.sv
hw/axi_rd_ctx_pipe.sv
hw/axi_rd_skid_buf.sv
hw/axi_rd_sub.sv
tests/axi_rd_checker.sv
tests/tb_axi_rd_sub.sv

/* hw/axi_rd_burst_seq.sv */
`timescale 1ns/1ps
`include "axi_rd_defines.svh"

module axi_rd_burst_seq (
    input  logic                  clk,
    input  logic                  rst_n,

    // AR channel
    input  logic                  i_ar_valid,
    output logic                  o_ar_ready,
    input  axi_rd_pkg::ar_req_t   i_ar,

    // All skid stages can take a beat
    input  logic                  i_space,

    // Component request side
    input  logic                  i_comp_hld,
    output logic                  o_comp_dv,
    output axi_rd_pkg::comp_req_t o_comp_req,
    output logic                  o_comp_last,

    // Issue strobe and beat context into the latency pipe
    output logic                  o_issue,
    output axi_rd_pkg::beat_ctx_t o_issue_ctx
);

    // Byte lane index bits of one data word
    localparam int BW = $clog2(`AXI_RD_DW / 8);

    // --------------------------------------------------------------------
    // Burst state
    // --------------------------------------------------------------------

    logic                 out_of_rst_q;
    logic                 active_q;
    axi_rd_pkg::ar_req_t  ctx_q;
    axi_rd_pkg::len_t     cnt_q;
    logic                 ar_xfer;
    logic                 final_beat;

    // Address math
    axi_rd_pkg::addr_t    beat_bytes;
    axi_rd_pkg::addr_t    addr_algn;
    axi_rd_pkg::addr_t    addr_incr;
    axi_rd_pkg::addr_t    wrap_mask;
    axi_rd_pkg::addr_t    addr_nxt;

    // Held low through reset and the first edge after it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_of_rst_q <= 1'b0;
        end else begin
            out_of_rst_q <= 1'b1;
        end
    end

    // Free for a new burst when idle or on the last component beat
    assign o_ar_ready = out_of_rst_q && (!active_q || final_beat);
    assign ar_xfer    = i_ar_valid && o_ar_ready;

    // Request only when the whole skid chain has room
    assign o_comp_dv  = active_q && i_space;
    assign o_issue    = o_comp_dv && !i_comp_hld;
    assign final_beat = o_issue && (cnt_q == '0);

    // Active drops after the final issue, data may still be in flight
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q <= 1'b0;
            cnt_q    <= '0;
        end else if (ar_xfer) begin
            active_q <= 1'b1;
            cnt_q    <= i_ar.len;
        end else if (o_issue) begin
            active_q <= !final_beat;
            // Hold at zero instead of wrapping
            cnt_q    <= (cnt_q == '0) ? cnt_q : cnt_q - 1'b1;
        end
    end

    // Request record, address walks with each issue
    always_ff @(posedge clk) begin
        if (ar_xfer) begin
            ctx_q <= i_ar;
        end else if (o_issue) begin
            ctx_q.addr <= addr_nxt;
        end
    end

    // --------------------------------------------------------------------
    // Next address from the full unaligned address
    // --------------------------------------------------------------------

    always_comb begin
        beat_bytes = axi_rd_pkg::addr_t'(1) << ctx_q.size;
        // First beat of an unaligned INCR snaps to the size boundary
        addr_algn  = ctx_q.addr & ~(beat_bytes - 1'b1);
        addr_incr  = addr_algn + beat_bytes;
        // Wrap window is (len+1) beats of 2^size bytes
        wrap_mask  = ((axi_rd_pkg::addr_t'(ctx_q.len) + 1'b1) << ctx_q.size) - 1'b1;
        case (ctx_q.burst)
            axi_rd_pkg::BURST_FIXED: addr_nxt = ctx_q.addr;
            axi_rd_pkg::BURST_WRAP:  addr_nxt = (ctx_q.addr & ~wrap_mask) |
                                                (addr_incr & wrap_mask);
            default:                 addr_nxt = addr_incr;
        endcase
    end

    // Component sees word aligned addresses only
    assign o_comp_req.addr = {ctx_q.addr[`AXI_RD_AW-1:BW], BW'(0)};
    assign o_comp_req.id   = ctx_q.id;
    assign o_comp_req.size = ctx_q.size;
    assign o_comp_last     = (cnt_q == '0);

    // Beat context, error is merged later at the data return
    assign o_issue_ctx.id   = ctx_q.id;
    assign o_issue_ctx.resp = axi_rd_pkg::RESP_OKAY;
    assign o_issue_ctx.last = (cnt_q == '0);

    // --------------------------------------------------------------------
    // Assertions
    // --------------------------------------------------------------------

    // Master keeps AR valid and payload until accepted
    a_ar_hold : assert property (@(posedge clk) disable iff (!rst_n)
        (i_ar_valid && !o_ar_ready) |=> (i_ar_valid && $stable(i_ar)));

    // No request after a burst closes without a new AR behind it
    a_dv_idle : assert property (@(posedge clk) disable iff (!rst_n)
        (final_beat && !ar_xfer) |=> !o_comp_dv);

endmodule

/* hw/axi_rd_ctx_pipe.sv */
`timescale 1ns/1ps

module axi_rd_ctx_pipe #(
    parameter int C_LAT = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // Issue side
    input  logic                  i_valid,
    input  axi_rd_pkg::beat_ctx_t i_ctx,

    // Aligned with the component rdata
    output logic                  o_valid,
    output axi_rd_pkg::beat_ctx_t o_ctx
);

    // --------------------------------------------------------------------
    // Delay line of C_LAT stages
    // --------------------------------------------------------------------

    // Index 0 is the live input, index C_LAT the delayed output
    logic                  vld [C_LAT+1];
    axi_rd_pkg::beat_ctx_t ctx [C_LAT+1];

    assign vld[0] = i_valid;
    assign ctx[0] = i_ctx;

    // With C_LAT zero the loop is empty and the pipe is a wire
    for (genvar k = 1; k <= C_LAT; k++) begin : g_stage

        // Valid bits are control, cleared on reset
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                vld[k] <= 1'b0;
            end else begin
                vld[k] <= vld[k-1];
            end
        end

        // Context only means something where valid is set
        always_ff @(posedge clk) begin
            ctx[k] <= ctx[k-1];
        end

    end : g_stage

    assign o_valid = vld[C_LAT];
    assign o_ctx   = ctx[C_LAT];

endmodule

/* hw/axi_rd_defines.svh */
`ifndef AXI_RD_DEFINES_SVH
`define AXI_RD_DEFINES_SVH

// --------------------------------------------------------------------
// Bus widths
// --------------------------------------------------------------------

// Byte address width on AR and on the component port
`define AXI_RD_AW 32

// Data width of one beat
// The component data width must equal the AXI data width
`define AXI_RD_DW 32

// Transaction ID width
`define AXI_RD_IW 4

// --------------------------------------------------------------------
// Component timing
// --------------------------------------------------------------------

// Default cycles from a component accept (dv and not hld) to rdata
// 0 suits register files, SRAMs usually need 1 or more
// The value is fixed per component
`define AXI_RD_C_LAT_DEF 2

`endif

/* hw/axi_rd_pkg.sv */
`include "axi_rd_defines.svh"

package axi_rd_pkg;

    // --------------------------------------------------------------------
    // Plain vector types
    // --------------------------------------------------------------------

    // Byte address
    typedef logic [`AXI_RD_AW-1:0] addr_t;
    // One data beat
    typedef logic [`AXI_RD_DW-1:0] data_t;
    // Transaction ID
    typedef logic [`AXI_RD_IW-1:0] id_t;
    // Burst length minus one
    typedef logic [7:0] len_t;
    // Log2 of bytes per beat
    typedef logic [2:0] size_t;

    // AXI burst encodings, reserved code 2'b11 not decoded
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } burst_e;

    // Only OKAY and SLVERR are ever returned
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    // --------------------------------------------------------------------
    // Packed channel and pipeline records
    // --------------------------------------------------------------------

    // AR channel payload
    typedef struct packed {
        addr_t  addr;
        burst_e burst;
        size_t  size;
        len_t   len;
        id_t    id;
    } ar_req_t;

    // Context that travels with each beat
    typedef struct packed {
        id_t   id;
        resp_e resp;
        logic  last;
    } beat_ctx_t;

    // Data plus context, also the R channel payload
    typedef struct packed {
        data_t     data;
        beat_ctx_t ctx;
    } rd_beat_t;

    // Request toward the component, addr is word aligned
    typedef struct packed {
        addr_t addr;
        id_t   id;
        size_t size;
    } comp_req_t;

endpackage

/* hw/axi_rd_skid_buf.sv */
`timescale 1ns/1ps

module axi_rd_skid_buf (
    input  logic                 clk,
    input  logic                 rst_n,

    // Upstream
    input  logic                 i_valid,
    output logic                 o_ready,
    input  axi_rd_pkg::rd_beat_t i_beat,

    // Downstream
    output logic                 o_valid,
    input  logic                 i_ready,
    output axi_rd_pkg::rd_beat_t o_beat
);

    // --------------------------------------------------------------------
    // One entry skid register
    // --------------------------------------------------------------------

    logic                 full_q;
    axi_rd_pkg::rd_beat_t skid_q;
    logic                 capture;
    logic                 drain;

    // Take a beat only when it would otherwise be lost
    assign capture = i_valid && !full_q && !i_ready;
    // Captured beat leaves once downstream accepts
    assign drain   = full_q && i_ready;

    // Ready depends only on local state, no comb path from i_ready
    assign o_ready = !full_q;

    // Empty means pass through in the same cycle
    assign o_valid = full_q || i_valid;
    assign o_beat  = full_q ? skid_q : i_beat;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full_q <= 1'b0;
        end else if (capture) begin
            full_q <= 1'b1;
        end else if (drain) begin
            full_q <= 1'b0;
        end
    end

    // Payload is guarded by full_q
    always_ff @(posedge clk) begin
        if (capture) begin
            skid_q <= i_beat;
        end
    end

    // --------------------------------------------------------------------
    // Assertions
    // --------------------------------------------------------------------

    // Upstream that is refused must keep the same beat
    // Stage 0 has no way to hold, so the sequencer must never cause this
    a_no_drop : assert property (@(posedge clk) disable iff (!rst_n)
        (i_valid && !o_ready) |=> (i_valid && $stable(i_beat)));

    // Stalled output holds until taken
    a_out_stable : assert property (@(posedge clk) disable iff (!rst_n)
        (o_valid && !i_ready) |=> (o_valid && $stable(o_beat)));

endmodule

/* hw/axi_rd_sub.sv */
`timescale 1ns/1ps
`include "axi_rd_defines.svh"

module axi_rd_sub #(
    parameter int C_LAT = `AXI_RD_C_LAT_DEF
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // AR channel
    input  logic                  i_ar_valid,
    output logic                  o_ar_ready,
    input  axi_rd_pkg::ar_req_t   i_ar,

    // R channel
    output logic                  o_r_valid,
    input  logic                  i_r_ready,
    output axi_rd_pkg::rd_beat_t  o_r,

    // Component port
    output logic                  o_comp_dv,
    output axi_rd_pkg::comp_req_t o_comp_req,
    output logic                  o_comp_last,
    input  logic                  i_comp_hld,
    input  logic                  i_comp_err,
    input  axi_rd_pkg::data_t     i_comp_rdata
);

    // --------------------------------------------------------------------
    // Request side
    // --------------------------------------------------------------------

    logic                  issue;
    axi_rd_pkg::beat_ctx_t issue_ctx;
    logic                  ret_valid;
    axi_rd_pkg::beat_ctx_t ret_ctx;
    logic                  space;

    // Skid chain, index C_LAT+1 faces the R channel
    logic [C_LAT+1:0]                 stg_valid;
    logic [C_LAT+1:0]                 stg_ready;
    axi_rd_pkg::rd_beat_t [C_LAT+1:0] stg_beat;

    axi_rd_burst_seq u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_ar_valid  (i_ar_valid),
        .o_ar_ready  (o_ar_ready),
        .i_ar        (i_ar),
        .i_space     (space),
        .i_comp_hld  (i_comp_hld),
        .o_comp_dv   (o_comp_dv),
        .o_comp_req  (o_comp_req),
        .o_comp_last (o_comp_last),
        .o_issue     (issue),
        .o_issue_ctx (issue_ctx)
    );

    // Context waits out the component latency
    axi_rd_ctx_pipe #(
        .C_LAT (C_LAT)
    ) u_ctx_pipe (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (issue),
        .i_ctx   (issue_ctx),
        .o_valid (ret_valid),
        .o_ctx   (ret_ctx)
    );

    // --------------------------------------------------------------------
    // Data return and skid chain
    // --------------------------------------------------------------------

    // Join rdata with its context, component error becomes SLVERR
    assign stg_valid[0]         = ret_valid;
    assign stg_beat[0].data     = i_comp_rdata;
    assign stg_beat[0].ctx.id   = ret_ctx.id;
    assign stg_beat[0].ctx.last = ret_ctx.last;
    assign stg_beat[0].ctx.resp = i_comp_err ? axi_rd_pkg::RESP_SLVERR : ret_ctx.resp;

    // One stage per beat that can be in flight
    for (genvar s = 0; s <= C_LAT; s++) begin : g_skid
        axi_rd_skid_buf u_skid (
            .clk     (clk),
            .rst_n   (rst_n),
            .i_valid (stg_valid[s]),
            .o_ready (stg_ready[s]),
            .i_beat  (stg_beat[s]),
            .o_valid (stg_valid[s+1]),
            .i_ready (stg_ready[s+1]),
            .o_beat  (stg_beat[s+1])
        );
    end : g_skid

    // Worst case room check, R ready itself is left out
    assign space = &stg_ready[C_LAT:0];

    assign stg_ready[C_LAT+1] = i_r_ready;
    assign o_r_valid          = stg_valid[C_LAT+1];
    assign o_r                = stg_beat[C_LAT+1];

    // Returned data always finds stage 0 empty
    a_ret_room : assert property (@(posedge clk) disable iff (!rst_n)
        stg_valid[0] |-> stg_ready[0]);

endmodule

/* tests/axi_rd_checker.sv */
`timescale 1ns/1ps
`include "axi_rd_defines.svh"

module axi_rd_checker #(
    parameter int C_LAT = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  i_ar_valid,
    input  logic                  i_ar_ready,
    input  axi_rd_pkg::ar_req_t   i_ar,
    input  logic                  i_r_valid,
    input  logic                  i_r_ready,
    input  axi_rd_pkg::rd_beat_t  i_r,
    input  logic                  i_comp_dv,
    input  logic                  i_comp_hld,
    input  axi_rd_pkg::comp_req_t i_comp_req,
    input  logic                  i_comp_last,
    // Latency must be exact only while R and the component never stall
    input  logic                  i_lat_check,
    output int                    o_errors,
    output int                    o_beats,
    output int                    o_pending
);

    // --------------------------------------------------------------------
    // Scoreboard state
    // --------------------------------------------------------------------

    axi_rd_pkg::rd_beat_t  exp_q [$];
    axi_rd_pkg::comp_req_t creq_q [$];
    logic                  clast_q [$];
    longint                acc_q [$];
    longint                cycle = 0;
    int                    errors = 0;
    int                    beats = 0;
    int                    pending = 0;
    logic                  stalled = 1'b0;
    axi_rd_pkg::rd_beat_t  held;

    assign o_errors  = errors;
    assign o_beats   = beats;
    assign o_pending = pending;

    task automatic value_error(string sig, logic [63:0] got, logic [63:0] exp);
        errors++;
        $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, sig, got, exp);
    endtask

    task automatic text_error(string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    // One AR request becomes len+1 expected beats
    function automatic void expand(axi_rd_pkg::ar_req_t req);
        axi_rd_pkg::addr_t     a;
        axi_rd_pkg::addr_t     nb;
        axi_rd_pkg::addr_t     span;
        axi_rd_pkg::addr_t     base;
        axi_rd_pkg::rd_beat_t  b;
        axi_rd_pkg::comp_req_t c;
        a    = req.addr;
        nb   = axi_rd_pkg::addr_t'(1) << req.size;
        span = nb * (req.len + 1);
        // Wrap boundary sits at a multiple of the whole burst size
        base = (a / span) * span;
        for (int n = 0; n <= req.len; n++) begin
            // Component sees the word address of each beat
            c.addr = a & ~(axi_rd_pkg::addr_t'(`AXI_RD_DW / 8) - 1);
            c.id   = req.id;
            c.size = req.size;
            creq_q.push_back(c);
            clast_q.push_back(n == req.len);
            // Component model data, keyed on the word address
            b.data     = c.addr ^ 32'hA5A5_0000;
            b.ctx.id   = req.id;
            b.ctx.resp = (a[11:8] == 4'hF) ? axi_rd_pkg::RESP_SLVERR : axi_rd_pkg::RESP_OKAY;
            b.ctx.last = (n == req.len);
            exp_q.push_back(b);
            if (req.burst == axi_rd_pkg::BURST_INCR) begin
                a = a + nb;
            end else if (req.burst == axi_rd_pkg::BURST_WRAP) begin
                a = a + nb;
                if (a == base + span) begin
                    a = base;
                end
            end
        end
    endfunction

    // --------------------------------------------------------------------
    // Component request compare
    // --------------------------------------------------------------------

    task automatic check_accept();
        axi_rd_pkg::comp_req_t exp_req;
        logic                  exp_last;
        if (creq_q.size() == 0) begin
            text_error("Component request issued with no burst outstanding");
            return;
        end
        exp_req  = creq_q.pop_front();
        exp_last = clast_q.pop_front();
        if (i_comp_req.addr !== exp_req.addr) begin
            value_error("o_comp_req.addr", i_comp_req.addr, exp_req.addr);
        end
        if (i_comp_req.id !== exp_req.id) begin
            value_error("o_comp_req.id", i_comp_req.id, exp_req.id);
        end
        if (i_comp_req.size !== exp_req.size) begin
            value_error("o_comp_req.size", i_comp_req.size, exp_req.size);
        end
        if (i_comp_last !== exp_last) begin
            value_error("o_comp_last", i_comp_last, exp_last);
        end
    endtask

    // --------------------------------------------------------------------
    // R beat compare
    // --------------------------------------------------------------------

    task automatic check_beat();
        axi_rd_pkg::rd_beat_t exp;
        longint               t_acc;
        beats++;
        if (exp_q.size() == 0) begin
            text_error("R beat arrived with no request outstanding");
            return;
        end
        exp = exp_q.pop_front();
        if (i_r.data !== exp.data) value_error("o_r.data", i_r.data, exp.data);
        if (i_r.ctx.id !== exp.ctx.id) value_error("o_r.id", i_r.ctx.id, exp.ctx.id);
        if (i_r.ctx.resp !== exp.ctx.resp) value_error("o_r.resp", i_r.ctx.resp, exp.ctx.resp);
        if (i_r.ctx.last !== exp.ctx.last) value_error("o_r.last", i_r.ctx.last, exp.ctx.last);
        if (acc_q.size() == 0) begin
            text_error("R beat has no matching component accept");
        end else begin
            t_acc = acc_q.pop_front();
            if (i_lat_check && (cycle - t_acc != C_LAT)) begin
                value_error("R latency", cycle - t_acc, C_LAT);
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            cycle++;
            if (i_comp_dv && !i_comp_hld) begin
                acc_q.push_back(cycle);
                check_accept();
            end
            if (i_ar_valid && i_ar_ready) begin
                expand(i_ar);
            end
            // Beat stalled at the last edge must still be on R unchanged
            if (stalled) begin
                if (!i_r_valid) begin
                    text_error("R valid dropped while a beat was stalled");
                end else if (i_r !== held) begin
                    value_error("o_r", i_r, held);
                end
            end
            stalled = i_r_valid && !i_r_ready;
            held    = i_r;
            if (i_r_valid && i_r_ready) begin
                check_beat();
            end
            pending = exp_q.size();
        end
    end

endmodule

/* tests/tb_axi_rd_sub.sv */
`timescale 1ns/1ps
`include "axi_rd_defines.svh"

module tb_axi_rd_sub;

    localparam int C_LAT   = `AXI_RD_C_LAT_DEF;
    localparam int CLK_PER = 100;
    localparam int N_RAND  = 40;
    localparam int N_LAT   = 10;
    // Watchdog budget, 300 cycles per burst
    localparam int WD_CYC  = (N_RAND + N_LAT) * 300;

    logic                  clk;
    logic                  rst_n;
    logic                  i_ar_valid;
    logic                  o_ar_ready;
    axi_rd_pkg::ar_req_t   i_ar;
    logic                  o_r_valid;
    logic                  i_r_ready;
    axi_rd_pkg::rd_beat_t  o_r;
    logic                  o_comp_dv;
    axi_rd_pkg::comp_req_t o_comp_req;
    logic                  o_comp_last;
    logic                  i_comp_hld;
    logic                  i_comp_err;
    axi_rd_pkg::data_t     i_comp_rdata;

    logic                  free_run;
    logic                  lat_check;
    string                 phase;
    int                    tb_errors;
    int                    chk_errors;
    int                    chk_beats;
    int                    chk_pending;
    int                    n_pass;
    int                    n_fail;

    // Component model delay line, index C_LAT drives the DUT
    axi_rd_pkg::data_t     mdl_data [C_LAT+1];
    logic                  mdl_err  [C_LAT+1];

    axi_rd_sub #(
        .C_LAT (C_LAT)
    ) axi_rd_sub_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_ar_valid   (i_ar_valid),
        .o_ar_ready   (o_ar_ready),
        .i_ar         (i_ar),
        .o_r_valid    (o_r_valid),
        .i_r_ready    (i_r_ready),
        .o_r          (o_r),
        .o_comp_dv    (o_comp_dv),
        .o_comp_req   (o_comp_req),
        .o_comp_last  (o_comp_last),
        .i_comp_hld   (i_comp_hld),
        .i_comp_err   (i_comp_err),
        .i_comp_rdata (i_comp_rdata)
    );

    axi_rd_checker #(
        .C_LAT (C_LAT)
    ) chk_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_ar_valid  (i_ar_valid),
        .i_ar_ready  (o_ar_ready),
        .i_ar        (i_ar),
        .i_r_valid   (o_r_valid),
        .i_r_ready   (i_r_ready),
        .i_r         (o_r),
        .i_comp_dv   (o_comp_dv),
        .i_comp_hld  (i_comp_hld),
        .i_comp_req  (o_comp_req),
        .i_comp_last (o_comp_last),
        .i_lat_check (lat_check),
        .o_errors    (chk_errors),
        .o_beats     (chk_beats),
        .o_pending   (chk_pending)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PER / 2) clk = ~clk;
    end

    // --------------------------------------------------------------------
    // Component model
    // --------------------------------------------------------------------

    initial begin : comp_model
        axi_rd_pkg::addr_t a;
        logic              acc;
        forever begin
            @(posedge clk);
            acc = o_comp_dv && !i_comp_hld;
            a   = o_comp_req.addr;
            #10;
            for (int k = C_LAT; k > 1; k--) begin
                mdl_data[k] = mdl_data[k-1];
                mdl_err[k]  = mdl_err[k-1];
            end
            mdl_data[1]  = acc ? (a ^ 32'hA5A5_0000) : '0;
            mdl_err[1]   = acc && (a[11:8] == 4'hF);
            i_comp_rdata = mdl_data[C_LAT];
            i_comp_err   = mdl_err[C_LAT];
        end
    end

    initial begin : watchdog
        #(WD_CYC * CLK_PER);
        $display("Timeout: %s did not finish within %0d cycles", phase, WD_CYC);
        $display("Test failed");
        $finish;
    end

    // --------------------------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------------------------

    // Random R stalls and component holds, both off in free run
    task automatic drive_stalls();
        forever begin
            @(posedge clk);
            #10;
            i_r_ready  = free_run || ($urandom_range(3, 0) != 0);
            i_comp_hld = !free_run && ($urandom_range(3, 0) == 0);
        end
    endtask

    function automatic axi_rd_pkg::ar_req_t make_req();
        axi_rd_pkg::ar_req_t req;
        req.id    = axi_rd_pkg::id_t'($urandom);
        req.size  = axi_rd_pkg::size_t'($urandom_range(2, 0));
        req.burst = axi_rd_pkg::burst_e'($urandom_range(2, 0));
        // WRAP needs 2, 4, 8 or 16 beats
        if (req.burst == axi_rd_pkg::BURST_WRAP) begin
            req.len = axi_rd_pkg::len_t'((2 << $urandom_range(3, 0)) - 1);
        end else begin
            req.len = axi_rd_pkg::len_t'($urandom_range(15, 0));
        end
        req.addr = $urandom;
        if ($urandom_range(3, 0) == 0) begin
            req.addr[11:8] = 4'hF;
        end
        // Keep INCR bursts inside one 4 KB page
        if (req.addr[11:6] == 6'h3F) begin
            req.addr[6] = 1'b0;
        end
        req.addr = req.addr & ~((axi_rd_pkg::addr_t'(1) << req.size) - 1);
        return req;
    endfunction

    // Called on a rising edge, returns on the edge of the last AR transfer
    task automatic send_bursts(int n);
        for (int b = 0; b < n; b++) begin
            #10;
            i_ar       = make_req();
            i_ar_valid = 1'b1;
            do begin
                @(posedge clk);
            end while (!o_ar_ready);
        end
        #10;
        i_ar_valid = 1'b0;
    endtask

    task automatic run_test(int num, string name, int n, logic free);
        int err0;
        err0      = tb_errors + chk_errors;
        phase     = name;
        free_run  = free;
        lat_check = free;
        @(posedge clk);
        send_bursts(n);
        do begin
            @(posedge clk);
            #1;
        end while (chk_pending != 0);
        report_test(num, name, tb_errors + chk_errors - err0);
    endtask

    task automatic report_test(int num, string name, int errs);
        if (errs == 0) n_pass++;
        else n_fail++;
        $display("Test %0d %s: %0d errors  %s", num, name, errs, (errs == 0) ? "PASS" : "FAIL");
    endtask

    task automatic check_low(logic val, string sig);
        if (val !== 1'b0) begin
            tb_errors++;
            $display("** Error at %0t: %s = %b, expected 0", $time, sig, val);
        end
    endtask

    // --------------------------------------------------------------------
    // Test sequence
    // --------------------------------------------------------------------

    initial begin
        void'($urandom(76));
        rst_n = 1'b0;
        i_ar_valid = 1'b0;
        i_ar = '0;
        i_r_ready = 1'b0;
        i_comp_hld = 1'b0;
        i_comp_err = 1'b0;
        i_comp_rdata = '0;
        free_run = 1'b0;
        lat_check = 1'b0;
        tb_errors = 0;
        n_pass = 0;
        n_fail = 0;
        for (int k = 0; k <= C_LAT; k++) begin
            mdl_data[k] = '0;
            mdl_err[k]  = 1'b0;
        end
        fork
            drive_stalls();
        join_none
        phase = "reset";
        repeat (3) begin
            @(posedge clk);
            check_low(o_ar_ready, "o_ar_ready");
            check_low(o_comp_dv, "o_comp_dv");
            check_low(o_r_valid, "o_r_valid");
        end
        report_test(1, "reset outputs", tb_errors);
        #10;
        rst_n = 1'b1;
        run_test(2, "random bursts with stalls", N_RAND, 1'b0);
        run_test(3, "free flow latency", N_LAT, 1'b1);
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d beats, %0d errors",
                 n_pass + n_fail, n_pass, n_fail, chk_beats, tb_errors + chk_errors);
        if (n_fail == 0 && tb_errors + chk_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
